//--- udp_pkg.sv
package udp_pkg;

	localparam logic [7:0] proto_udp = 8'h11;
	localparam logic [7:0] ip_ttl = 8'h40;	// time-to-live on replies

	// udp header as the user supplies it for transmit
	typedef struct packed {
		logic [15:0] src_port;
		logic [15:0] dst_port;
		logic [15:0] length;	// header plus payload, in bytes
		logic [15:0] checksum;	// zero means not used
	} udp_tx_head_t;

	// one header word, shifted a byte at a time or read by field
	typedef union packed {
		logic [63:0] raw;	// first byte on the wire sits in [63:56]
		udp_tx_head_t fields;
	} udp_head_u;

	// header info from the ipv4 layer, valid with newhead
	typedef struct packed {
		logic newhead;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [7:0] protocol;
		logic [3:0] ihl;	// in 32-bit words
		logic [15:0] identification;
	} ip_rx_head_t;

	// one beat of a byte stream
	typedef struct packed {
		logic [7:0] data;
		logic dven;
		logic error;
	} byte_strm_t;

	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] src_port;
		logic [15:0] dst_port;
		logic [15:0] length;
	} udp_meta_t;

	// fields handed to the ipv4 transmitter
	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [7:0] protocol;
		logic [7:0] ttl;
		logic [15:0] total_length;
		logic [15:0] identification;
		logic [3:0] ihl;
	} ip_tx_head_t;

endpackage

//--- byte_fifo.sv
module byte_fifo #(
	parameter int aw = 5
) (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [7:0] din,
	input logic rd_en,
	output logic [7:0] dout,
	output logic dout_valid,
	output logic empty,
	output logic full
);

	logic [7:0] mem [0:(1 << aw) - 1];
	logic [aw:0] wr_ptr;	// top bit flips on every wrap
	logic [aw:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[aw-1:0]] <= din;
		if (do_rd)
			dout <= mem[rd_ptr[aw-1:0]];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			dout_valid <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			dout_valid <= do_rd;	// dout lands one cycle after the read
		end
	end

endmodule

//--- udp_csum_acc.sv
module udp_csum_acc (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic word_en,
	input logic [15:0] word,
	input logic byte_en,
	input logic [7:0] byte_in,
	output logic [15:0] sum
);

	logic [15:0] acc;
	logic [7:0] hi_byte;	// first byte of a pair, waiting for its partner
	logic have_hi;
	logic [15:0] acc_w;
	logic [15:0] acc_wb;

	// ones-complement add, carry wrapped back into bit 0
	function automatic logic [15:0] add_oc(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = a + b;
		return s[15:0] + {15'd0, s[16]};
	endfunction

	assign acc_w = word_en ? add_oc(acc, word) : acc;
	assign acc_wb = (byte_en && have_hi) ? add_oc(acc_w, {hi_byte, byte_in}) : acc_w;

	// odd trailing byte counts as the high half of a zero-padded word
	assign sum = have_hi ? add_oc(acc, {hi_byte, 8'h00}) : acc;

	always_ff @(posedge clk) begin
		if (byte_en && !have_hi)
			hi_byte <= byte_in;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc <= '0;
			have_hi <= 1'b0;
		end else if (clear) begin
			acc <= '0;
			have_hi <= 1'b0;
		end else begin
			acc <= acc_wb;
			if (byte_en)
				have_hi <= !have_hi;
		end
	end

endmodule

//--- udp_rx_parser.sv
module udp_rx_parser import udp_pkg::*; (
	input logic clk,
	input logic reset,
	input ip_rx_head_t ip_rx_head,
	input byte_strm_t ip_rx,
	output byte_strm_t usr_rx,
	output udp_meta_t usr_rx_meta,
	output logic usr_rx_done,
	output logic usr_rx_err,
	output ip_rx_head_t reply_head
);

	typedef enum logic [1:0] {
		st_idle,
		st_head,
		st_payload,
		st_tail
	} rx_state_t;

	rx_state_t state;
	rx_state_t state_nxt;
	ip_rx_head_t head_q;
	byte_strm_t rx_q;
	logic match;
	logic [15:0] rx_cnt;	// udp bytes seen, header included
	udp_head_u udp_head;
	udp_head_u head_nxt;
	logic err_seen;
	logic byte_en;
	logic word_en;
	logic [15:0] ph_word;
	logic [15:0] csum;
	logic csum_bad;
	logic len_bad;

	assign match = head_q.newhead && (head_q.protocol == proto_udp);
	assign byte_en = ((state == st_head) || (state == st_payload)) && rx_q.dven;
	assign head_nxt.raw = {udp_head.raw[55:0], rx_q.data};

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (match)
					state_nxt = st_head;
			end
			st_head: begin
				if (!rx_q.dven)
					state_nxt = st_tail;	// runt, length check flags it
				else if (rx_cnt == 16'd7)
					state_nxt = st_payload;
			end
			st_payload: begin
				if (!rx_q.dven)
					state_nxt = st_tail;
			end
			default: state_nxt = st_idle;
		endcase
	end

	// pseudo header words, one per header byte cycle
	assign word_en = (state == st_head) && rx_q.dven && (rx_cnt < 16'd6);

	always_comb begin
		case (rx_cnt[2:0])
			3'd0: ph_word = reply_head.src_ip[31:16];
			3'd1: ph_word = reply_head.src_ip[15:0];
			3'd2: ph_word = reply_head.dst_ip[31:16];
			3'd3: ph_word = reply_head.dst_ip[15:0];
			3'd4: ph_word = {8'h00, proto_udp};
			default: ph_word = head_nxt.raw[15:0];	// length, complete at byte 5
		endcase
	end

	udp_csum_acc u_csum (
		.clk(clk),
		.reset(reset),
		.clear(state == st_idle),
		.word_en(word_en),
		.word(ph_word),
		.byte_en(byte_en),
		.byte_in(rx_q.data),
		.sum(csum)
	);

	assign csum_bad = (udp_head.fields.checksum != 16'h0000) && (csum != 16'hffff);
	assign len_bad = (rx_cnt != udp_head.fields.length);

	always_ff @(posedge clk) begin
		if ((state == st_head) && rx_q.dven)
			udp_head <= head_nxt;
		if ((state == st_head) && (state_nxt == st_payload)) begin
			usr_rx_meta.src_ip <= reply_head.src_ip;
			usr_rx_meta.dst_ip <= reply_head.dst_ip;
			usr_rx_meta.src_port <= head_nxt.fields.src_port;
			usr_rx_meta.dst_port <= head_nxt.fields.dst_port;
			usr_rx_meta.length <= head_nxt.fields.length;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head_q <= '0;
			rx_q <= '0;
			state <= st_idle;
			rx_cnt <= '0;
			err_seen <= 1'b0;
			reply_head <= '0;
			usr_rx <= '0;
			usr_rx_done <= 1'b0;
			usr_rx_err <= 1'b0;
		end else begin
			head_q <= ip_rx_head;
			rx_q <= ip_rx;
			state <= state_nxt;
			if (state == st_idle)
				rx_cnt <= '0;
			else if (byte_en)
				rx_cnt <= rx_cnt + 16'd1;
			if (state == st_idle)
				err_seen <= 1'b0;
			else if (byte_en && rx_q.error)
				err_seen <= 1'b1;
			// newhead stays set once any datagram was taken
			if ((state == st_idle) && match)
				reply_head <= head_q;
			usr_rx.data <= rx_q.data;
			usr_rx.dven <= (state == st_payload) && rx_q.dven;
			usr_rx.error <= (state == st_payload) && rx_q.error;
			usr_rx_done <= (state_nxt == st_tail);
			if (state_nxt == st_tail)
				usr_rx_err <= err_seen | csum_bad | len_bad;	// held until next done
		end
	end

endmodule

//--- udp_tx_framer.sv
module udp_tx_framer import udp_pkg::*; #(
	parameter int fifo_aw = 5
) (
	input logic clk,
	input logic reset,
	input logic usr_tx_request,
	input logic ip_ack,
	output logic ip_request,
	output logic usr_tx_ack,
	input udp_tx_head_t usr_tx_head,
	input byte_strm_t usr_tx,
	input ip_rx_head_t reply_head,
	output byte_strm_t ip_tx,
	output ip_tx_head_t ip_tx_head
);

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_head,
		st_payload,
		st_tail
	} tx_state_t;

	tx_state_t state;
	tx_state_t state_nxt;
	byte_strm_t usr_q;
	udp_head_u head_sr;
	logic [2:0] head_cnt;
	logic [7:0] tx_data;
	logic tx_dven;
	logic fifo_rd;
	logic fifo_empty;
	logic [7:0] fifo_dout;
	logic fifo_valid;

	assign usr_tx_ack = ip_ack;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (ip_ack)
					state_nxt = st_start;
			end
			st_start: begin
				if (usr_q.dven)
					state_nxt = st_head;	// byte 0 of the header leaves now
			end
			st_head: begin
				if (head_cnt == 3'd7)
					state_nxt = st_payload;
			end
			st_payload: begin
				if (!fifo_valid)
					state_nxt = st_tail;
			end
			default: state_nxt = st_idle;
		endcase
	end

	// read ahead on the last header cycle, fifo latency plus output reg
	assign fifo_rd = (((state == st_head) && (head_cnt == 3'd7)) || (state == st_payload))
		&& !fifo_empty;

	byte_fifo #(.aw(fifo_aw)) u_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(usr_q.dven),
		.din(usr_q.data),
		.rd_en(fifo_rd),
		.dout(fifo_dout),
		.dout_valid(fifo_valid),
		.empty(fifo_empty),
		.full()
	);

	always_ff @(posedge clk) begin
		if ((state == st_start) && usr_q.dven)
			head_sr.raw <= {head_sr.raw[55:0], 8'h00};
		else if (state == st_start && usr_tx.dven)
			head_sr.fields <= usr_tx_head;	// first user byte
		else if (state == st_head)
			head_sr.raw <= {head_sr.raw[55:0], 8'h00};
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ip_request <= 1'b0;
			usr_q <= '0;
			state <= st_idle;
			head_cnt <= 3'd1;
			tx_data <= '0;
			tx_dven <= 1'b0;
		end else begin
			if (usr_tx_request)
				ip_request <= 1'b1;
			else if (ip_ack)
				ip_request <= 1'b0;
			usr_q <= usr_tx;
			state <= state_nxt;
			head_cnt <= (state == st_head) ? head_cnt + 3'd1 : 3'd1;
			tx_dven <= 1'b0;
			case (state)
				st_start: begin
					if (usr_q.dven) begin
						tx_data <= head_sr.raw[63:56];
						tx_dven <= 1'b1;
					end
				end
				st_head: begin
					tx_data <= head_sr.raw[63:56];
					tx_dven <= 1'b1;
				end
				st_payload: begin
					tx_data <= fifo_dout;
					tx_dven <= fifo_valid;
				end
				default: tx_data <= '0;
			endcase
		end
	end

	assign ip_tx = '{data: tx_data, dven: tx_dven, error: 1'b0};

	// reply goes back where the last datagram came from
	always_comb begin
		ip_tx_head.src_ip = reply_head.dst_ip;
		ip_tx_head.dst_ip = reply_head.src_ip;
		ip_tx_head.protocol = proto_udp;
		ip_tx_head.ttl = ip_ttl;
		ip_tx_head.total_length = {10'd0, reply_head.ihl, 2'b00} + usr_tx_head.length;
		ip_tx_head.identification = reply_head.identification;
		ip_tx_head.ihl = reply_head.ihl;
	end

endmodule

//--- udp_over_ipv4.sv
module udp_over_ipv4 import udp_pkg::*; #(
	parameter int fifo_aw = 5
) (
	input logic clk,
	input logic reset,
	input ip_rx_head_t ip_rx_head,
	input byte_strm_t ip_rx,
	output byte_strm_t ip_tx,
	output ip_tx_head_t ip_tx_head,
	output logic ip_request,
	input logic ip_ack,
	output byte_strm_t usr_rx,
	output udp_meta_t usr_rx_meta,
	output logic usr_rx_done,
	output logic usr_rx_err,
	input logic usr_tx_request,
	output logic usr_tx_ack,
	input udp_tx_head_t usr_tx_head,
	input byte_strm_t usr_tx
);

	ip_rx_head_t reply_head;	// last accepted ipv4 header

	udp_rx_parser u_rx (
		.clk(clk),
		.reset(reset),
		.ip_rx_head(ip_rx_head),
		.ip_rx(ip_rx),
		.usr_rx(usr_rx),
		.usr_rx_meta(usr_rx_meta),
		.usr_rx_done(usr_rx_done),
		.usr_rx_err(usr_rx_err),
		.reply_head(reply_head)
	);

	udp_tx_framer #(.fifo_aw(fifo_aw)) u_tx (
		.clk(clk),
		.reset(reset),
		.usr_tx_request(usr_tx_request),
		.ip_ack(ip_ack),
		.ip_request(ip_request),
		.usr_tx_ack(usr_tx_ack),
		.usr_tx_head(usr_tx_head),
		.usr_tx(usr_tx),
		.reply_head(reply_head),
		.ip_tx(ip_tx),
		.ip_tx_head(ip_tx_head)
	);

endmodule

//--- udp_sva.sv
module udp_sva (
	input logic clk,
	input logic reset,
	input logic ip_request,
	input logic ip_ack,
	input logic usr_rx_done,
	input logic usr_rx_dven,
	input logic ip_tx_dven
);
	timeunit 1ns;
	timeprecision 1ns;

	logic tx_busy;	// framer out of idle, from ack to end of datagram
	logic tx_dven_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_busy <= 1'b0;
			tx_dven_q <= 1'b0;
		end else begin
			tx_dven_q <= ip_tx_dven;
			if (ip_ack)
				tx_busy <= 1'b1;
			else if (tx_dven_q && !ip_tx_dven)
				tx_busy <= 1'b0;
		end
	end

	req_drop: assert property (@(posedge clk) disable iff (reset)
		$fell(ip_request) |-> $past(ip_ack))
		else $error("ip_request fell without an ip_ack the cycle before");

	done_alone: assert property (@(posedge clk) disable iff (reset)
		!(usr_rx_done && usr_rx_dven))
		else $error("usr_rx_done high together with usr_rx.dven");

	tx_quiet: assert property (@(posedge clk) disable iff (reset)
		ip_tx_dven |-> tx_busy)
		else $error("ip_tx.dven high while the framer is idle");

endmodule

//--- udp_tb.sv
module udp_tb import udp_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int cycle_limit = 3000;
	localparam int rx_pay = 13;
	localparam int tx_pay = 10;
	localparam logic [31:0] peer_ip = 32'hc0a8_0107;
	localparam logic [31:0] local_ip = 32'hc0a8_0102;
	localparam logic [15:0] peer_port = 16'hd431;
	localparam logic [15:0] local_port = 16'h0bb8;
	localparam logic [15:0] rx_ident = 16'h4c2e;

	logic clk;
	logic reset;
	ip_rx_head_t ip_rx_head;
	byte_strm_t ip_rx;
	byte_strm_t ip_tx;
	ip_tx_head_t ip_tx_head;
	logic ip_request;
	logic ip_ack;
	byte_strm_t usr_rx;
	udp_meta_t usr_rx_meta;
	logic usr_rx_done;
	logic usr_rx_err;
	logic usr_tx_request;
	logic usr_tx_ack;
	udp_tx_head_t usr_tx_head;
	byte_strm_t usr_tx;

	logic [15:0] lfsr;
	logic [7:0] pkt [0:63];	// udp bytes as on the wire, header first
	logic [15:0] good_csum;
	int cycles;

	udp_over_ipv4 #(.fifo_aw(5)) uut (
		.clk(clk),
		.reset(reset),
		.ip_rx_head(ip_rx_head),
		.ip_rx(ip_rx),
		.ip_tx(ip_tx),
		.ip_tx_head(ip_tx_head),
		.ip_request(ip_request),
		.ip_ack(ip_ack),
		.usr_rx(usr_rx),
		.usr_rx_meta(usr_rx_meta),
		.usr_rx_done(usr_rx_done),
		.usr_rx_err(usr_rx_err),
		.usr_tx_request(usr_tx_request),
		.usr_tx_ack(usr_tx_ack),
		.usr_tx_head(usr_tx_head),
		.usr_tx(usr_tx)
	);

	bind udp_over_ipv4 udp_sva chk (
		.clk(clk),
		.reset(reset),
		.ip_request(ip_request),
		.ip_ack(ip_ack),
		.usr_rx_done(usr_rx_done),
		.usr_rx_dven(usr_rx.dven),
		.ip_tx_dven(ip_tx.dven)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("Test FAILED");
			$fatal(1, "simulation ran past %0d cycles without finishing", cycle_limit);
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		int i;
		b = 8'h00;
		for (i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// ones-complement sum of pseudo header and pkt[0..n-1]
	function automatic logic [15:0] pseudo_sum(input logic [31:0] sip, input logic [31:0] dip,
		input int n);
		logic [31:0] s;
		int i;
		s = {16'd0, sip[31:16]} + {16'd0, sip[15:0]} + {16'd0, dip[31:16]} + {16'd0, dip[15:0]};
		s = s + {24'd0, proto_udp} + 32'(n);
		for (i = 0; i < n; i += 2)
			s = s + {16'd0, pkt[i], (i + 1 < n) ? pkt[i + 1] : 8'h00};
		while (s[31:16] != 16'd0)
			s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		return s[15:0];
	endfunction

	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ipv4 side of one datagram, checks usr_rx beat by beat
	task automatic send_dgram(input logic [7:0] proto, input logic [31:0] sip,
		input logic [31:0] dip, input logic [15:0] ident, input logic [15:0] csum,
		input int err_at, input logic exp_err);
		int n;
		int t;
		logic claim;
		logic exp_dven;
		n = 8 + rx_pay;
		claim = (proto == proto_udp);
		pkt[6] = csum[15:8];
		pkt[7] = csum[7:0];
		ip_rx_head = '{newhead: 1'b1, src_ip: sip, dst_ip: dip, protocol: proto,
			ihl: 4'd5, identification: ident};
		tick();
		ip_rx_head.newhead = 1'b0;
		for (t = 0; t < n + 4; t++) begin
			exp_dven = claim && (t >= 10) && (t < n + 2);	// two cycles behind ip_rx
			check_val("usr_rx.dven", 64'(usr_rx.dven), 64'(exp_dven));
			if (exp_dven) begin
				check_val("usr_rx.data", 64'(usr_rx.data), 64'(pkt[t - 2]));
				check_val("usr_rx.error", 64'(usr_rx.error), 64'(t - 2 == err_at));
			end
			if (claim && t == 10) begin
				check_val("usr_rx_meta.src_ip", 64'(usr_rx_meta.src_ip), 64'(sip));
				check_val("usr_rx_meta.dst_ip", 64'(usr_rx_meta.dst_ip), 64'(dip));
				check_val("usr_rx_meta.src_port", 64'(usr_rx_meta.src_port), 64'(peer_port));
				check_val("usr_rx_meta.dst_port", 64'(usr_rx_meta.dst_port), 64'(local_port));
				check_val("usr_rx_meta.length", 64'(usr_rx_meta.length), 64'(n));
			end
			check_val("usr_rx_done", 64'(usr_rx_done), 64'(claim && t == n + 2));
			if (claim && t == n + 2)
				check_val("usr_rx_err", 64'(usr_rx_err), 64'(exp_err));
			if (t < n)
				ip_rx = '{data: pkt[t], dven: 1'b1, error: (t == err_at)};
			else
				ip_rx = '{data: 8'h00, dven: 1'b0, error: 1'b0};
			tick();
		end
	endtask

	task automatic check_reset_state();
		check_val("ip_request", 64'(ip_request), 64'd0);
		check_val("ip_tx.dven", 64'(ip_tx.dven), 64'd0);
		check_val("usr_rx.dven", 64'(usr_rx.dven), 64'd0);
		check_val("usr_rx_done", 64'(usr_rx_done), 64'd0);
		check_val("usr_tx_ack", 64'(usr_tx_ack), 64'd0);
		check_val("usr_rx_err", 64'(usr_rx_err), 64'd0);
	endtask

	task automatic receive_good();
		int i;
		pkt[0] = peer_port[15:8];
		pkt[1] = peer_port[7:0];
		pkt[2] = local_port[15:8];
		pkt[3] = local_port[7:0];
		pkt[4] = 8'h00;
		pkt[5] = 8'(8 + rx_pay);
		pkt[6] = 8'h00;
		pkt[7] = 8'h00;
		for (i = 8; i < 8 + rx_pay; i++)
			rand_byte(pkt[i]);
		good_csum = ~pseudo_sum(peer_ip, local_ip, 8 + rx_pay);
		if (good_csum == 16'h0000)
			good_csum = 16'hffff;	// zero would mean no checksum
		send_dgram(proto_udp, peer_ip, local_ip, rx_ident, good_csum, -1, 1'b0);
	endtask

	task automatic receive_faults();
		send_dgram(proto_udp, peer_ip, local_ip, rx_ident, good_csum ^ 16'h0004, -1, 1'b1);
		send_dgram(proto_udp, peer_ip, local_ip, rx_ident, 16'h0000, -1, 1'b0);
		send_dgram(proto_udp, peer_ip, local_ip, rx_ident, good_csum, 12, 1'b1);
	endtask

	task automatic ignore_other_proto();
		send_dgram(8'h06, 32'h0a00_0009, 32'h0a00_0003, 16'h0777, good_csum, -1, 1'b0);
	endtask

	task automatic transmit_reply();
		int n;
		int t;
		logic exp_dven;
		udp_tx_head_t th;
		n = 8 + tx_pay;
		th = '{src_port: local_port, dst_port: peer_port, length: 16'(n), checksum: 16'h9e21};
		pkt[0] = th.src_port[15:8];
		pkt[1] = th.src_port[7:0];
		pkt[2] = th.dst_port[15:8];
		pkt[3] = th.dst_port[7:0];
		pkt[4] = th.length[15:8];
		pkt[5] = th.length[7:0];
		pkt[6] = th.checksum[15:8];
		pkt[7] = th.checksum[7:0];
		for (t = 8; t < n; t++)
			rand_byte(pkt[t]);
		usr_tx_request = 1'b1;
		tick();
		usr_tx_request = 1'b0;
		check_val("ip_request", 64'(ip_request), 64'd1);
		check_val("usr_tx_ack", 64'(usr_tx_ack), 64'd0);
		// ipv4 layer grants a little later
		tick();
		tick();
		check_val("ip_request", 64'(ip_request), 64'd1);
		ip_ack = 1'b1;
		tick();
		check_val("usr_tx_ack", 64'(usr_tx_ack), 64'd1);
		check_val("ip_request", 64'(ip_request), 64'd0);
		ip_ack = 1'b0;
		tick();
		check_val("usr_tx_ack", 64'(usr_tx_ack), 64'd0);
		check_val("ip_request", 64'(ip_request), 64'd0);
		usr_tx_head = th;
		for (t = 0; t < n + 4; t++) begin
			exp_dven = (t >= 2) && (t < n + 2);
			check_val("ip_tx.dven", 64'(ip_tx.dven), 64'(exp_dven));
			check_val("ip_tx.error", 64'(ip_tx.error), 64'd0);
			if (exp_dven)
				check_val("ip_tx.data", 64'(ip_tx.data), 64'(pkt[t - 2]));
			if (t == 4) begin
				check_val("ip_tx_head.src_ip", 64'(ip_tx_head.src_ip), 64'(local_ip));
				check_val("ip_tx_head.dst_ip", 64'(ip_tx_head.dst_ip), 64'(peer_ip));
				check_val("ip_tx_head.protocol", 64'(ip_tx_head.protocol), 64'h11);
				check_val("ip_tx_head.ttl", 64'(ip_tx_head.ttl), 64'h40);
				check_val("ip_tx_head.total_length", 64'(ip_tx_head.total_length),
					64'(16'd20 + th.length));
				check_val("ip_tx_head.identification", 64'(ip_tx_head.identification),
					64'(rx_ident));
				check_val("ip_tx_head.ihl", 64'(ip_tx_head.ihl), 64'd5);
			end
			if (t < tx_pay)
				usr_tx = '{data: pkt[8 + t], dven: 1'b1, error: 1'b0};
			else
				usr_tx = '{data: 8'h00, dven: 1'b0, error: 1'b0};
			tick();
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ip_rx_head = '0;
		ip_rx = '0;
		ip_ack = 1'b0;
		usr_tx_request = 1'b0;
		usr_tx_head = '0;
		usr_tx = '0;
		lfsr = 16'd26;
		cycles = 0;
		repeat (4) tick();
		reset = 1'b0;
		tick();
		check_reset_state();
		receive_good();
		receive_faults();
		ignore_other_proto();
		transmit_reply();
		$display("Test OK");
		$finish;
	end

endmodule

//--- build.f
udp_pkg.sv
byte_fifo.sv
udp_csum_acc.sv
udp_rx_parser.sv
udp_tx_framer.sv
udp_over_ipv4.sv
udp_sva.sv
udp_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns --top-module udp_tb -f build.f -o udp_sim &&
./obj_dir/udp_sim || exit 1
